//--- Bender.yml
package:
  name: separate_caches

sources:
  - include_dirs:
      - .
    files:
      - cache_pkg.sv
      - direct_mapped_cache.sv
      - fence_sequencer.sv
      - mem_arbiter.sv
      - separate_caches.sv
  - target: test
    include_dirs:
      - .
    files:
      - separate_caches_sva.sv
      - tb_separate_caches.sv

//--- cache_defines.svh
// address and data widths, line count, uncached boundary and cache instance count
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// ----------------------------------------------------------------------
// bus widths
// ----------------------------------------------------------------------
`define CACHE_ADDR_W 32
`define CACHE_DATA_W 32

// ----------------------------------------------------------------------
// cache geometry
// ----------------------------------------------------------------------
// lines per cache, one word each
`define CACHE_SETS 16
// everything from here up bypasses the arrays
`define CACHE_NONCACHE_START 32'hF000_0000
// index 0 is the instruction cache, index 1 the data cache
`define CACHE_COUNT 2

`endif

//--- cache_pkg.sv
// cache controller, fence opcode and arbiter state enums
package cache_pkg;

    // per-cache controller
    typedef enum logic [2:0] {
        IDLE,
        WRITEBACK,
        FILL,
        UNCACHED,
        FLUSH_SCAN,
        FLUSH_WB
    } cache_state_t;

    // fence opcodes from the pipeline
    typedef enum logic [1:0] {
        FENCE_I,
        FENCE_D,
        FENCE_ALL
    } fence_op_t;

    typedef enum logic {ARB_IDLE, ARB_BUSY} arb_state_t;

endpackage

//--- direct_mapped_cache.sv
// direct-mapped write-back cache with flush and clear walks and an uncached bypass
`timescale 1ns/100ps
`include "cache_defines.svh"

module direct_mapped_cache
    import cache_pkg::*;
(
    input  logic                     CLK,
    input  logic                     rst,
    input  logic [`CACHE_ADDR_W-1:0] proc_addr,
    input  logic                     proc_ren,
    input  logic                     proc_wen,
    input  logic [`CACHE_DATA_W-1:0] proc_wdata,
    output logic [`CACHE_DATA_W-1:0] proc_rdata,
    output logic                     proc_busy,
    output logic [`CACHE_ADDR_W-1:0] mem_addr,
    output logic                     mem_ren,
    output logic                     mem_wen,
    output logic [`CACHE_DATA_W-1:0] mem_wdata,
    input  logic [`CACHE_DATA_W-1:0] mem_rdata,
    input  logic                     mem_busy,
    input  logic                     flush,
    input  logic                     clear,
    output logic                     flush_done,
    output logic                     clear_done
);
    localparam int IDX_W = $clog2(`CACHE_SETS);
    localparam int TAG_W = `CACHE_ADDR_W - IDX_W - 2;

    logic [`CACHE_SETS-1:0]   valid;
    logic [`CACHE_SETS-1:0]   dirty;
    logic [TAG_W-1:0]         tags  [`CACHE_SETS];
    logic [`CACHE_DATA_W-1:0] words [`CACHE_SETS];

    cache_state_t     state;
    logic [IDX_W-1:0] line_cnt;
    logic             walk_flush;

    logic [IDX_W-1:0] idx;
    logic [TAG_W-1:0] ptag;
    logic             req;
    logic             uncached;
    logic             hit;
    logic             walk_req;
    logic             last_line;

    // word addressed, byte offset ignored
    assign idx       = proc_addr[IDX_W+1:2];
    assign ptag      = proc_addr[`CACHE_ADDR_W-1:IDX_W+2];
    assign req       = proc_ren | proc_wen;
    assign uncached  = proc_addr >= `CACHE_NONCACHE_START;
    assign hit       = valid[idx] & (tags[idx] == ptag) & ~uncached;
    assign walk_req  = (flush & ~flush_done) | (clear & ~clear_done);
    assign last_line = line_cnt == IDX_W'(`CACHE_SETS - 1);

    // ----------------------------------------------------------------------
    // processor side
    // ----------------------------------------------------------------------
    always_comb begin
        proc_busy  = 1'b0;
        proc_rdata = words[idx];
        if (req) begin
            case (state)
                IDLE:     proc_busy = walk_req | ~hit;
                UNCACHED: begin
                    proc_busy  = mem_busy;
                    proc_rdata = mem_rdata;
                end
                default:  proc_busy = 1'b1;
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // memory side
    // ----------------------------------------------------------------------
    always_comb begin
        mem_addr  = '0;
        mem_wdata = '0;
        mem_ren   = 1'b0;
        mem_wen   = 1'b0;
        case (state)
            WRITEBACK: begin
                mem_addr  = {tags[idx], idx, 2'b00};
                mem_wdata = words[idx];
                mem_wen   = 1'b1;
            end
            FILL: begin
                mem_addr = {ptag, idx, 2'b00};
                mem_ren  = 1'b1;
            end
            // single pass-through transaction
            UNCACHED: begin
                mem_addr  = proc_addr;
                mem_wdata = proc_wdata;
                mem_ren   = proc_ren;
                mem_wen   = proc_wen;
            end
            FLUSH_WB: begin
                mem_addr  = {tags[line_cnt], line_cnt, 2'b00};
                mem_wdata = words[line_cnt];
                mem_wen   = 1'b1;
            end
            default: ;
        endcase
    end

    // controller, line status and fence walk
    always_ff @(posedge CLK) begin
        if (rst) begin
            state      <= IDLE;
            valid      <= '0;
            dirty      <= '0;
            line_cnt   <= '0;
            walk_flush <= 1'b0;
            flush_done <= 1'b0;
            clear_done <= 1'b0;
        end else begin
            if (!flush) flush_done <= 1'b0;
            if (!clear) clear_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (walk_req) begin
                        // flush goes first when both are pending
                        walk_flush <= flush & ~flush_done;
                        line_cnt   <= '0;
                        state      <= FLUSH_SCAN;
                    end else if (req) begin
                        if (uncached) state <= UNCACHED;
                        else if (hit) dirty[idx] <= dirty[idx] | proc_wen;
                        else if (valid[idx] & dirty[idx]) state <= WRITEBACK;
                        else state <= FILL;
                    end
                end
                WRITEBACK: if (!mem_busy) state <= FILL;
                FILL: begin
                    if (!mem_busy) begin
                        valid[idx] <= 1'b1;
                        dirty[idx] <= 1'b0;
                        state      <= IDLE;
                    end
                end
                UNCACHED: if (!mem_busy) state <= IDLE;
                FLUSH_SCAN: begin
                    if (walk_flush & valid[line_cnt] & dirty[line_cnt]) begin
                        state <= FLUSH_WB;
                    end else begin
                        valid[line_cnt] <= 1'b0;
                        dirty[line_cnt] <= 1'b0;
                        if (last_line) begin
                            if (walk_flush) flush_done <= 1'b1;
                            else clear_done <= 1'b1;
                            state <= IDLE;
                        end else begin
                            line_cnt <= line_cnt + 1'b1;
                        end
                    end
                end
                // back to scan, which then invalidates this line
                FLUSH_WB: begin
                    if (!mem_busy) begin
                        dirty[line_cnt] <= 1'b0;
                        state           <= FLUSH_SCAN;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // tag and data arrays
    always_ff @(posedge CLK) begin
        if (state == FILL && !mem_busy) begin
            tags[idx]  <= ptag;
            words[idx] <= mem_rdata;
        end else if (state == IDLE && !walk_req && hit && proc_wen) begin
            words[idx] <= proc_wdata;
        end
    end

endmodule

//--- fence_sequencer.sv
// fence sequencer driving per-cache flush and clear levels until each reports done
`timescale 1ns/100ps
`include "cache_defines.svh"

module fence_sequencer
    import cache_pkg::*;
(
    input  logic                    CLK,
    input  logic                    rst,
    input  logic                    fence_req,
    input  fence_op_t               fence_op,
    output logic                    fence_busy,
    output logic [`CACHE_COUNT-1:0] flush,
    output logic [`CACHE_COUNT-1:0] clear,
    input  logic [`CACHE_COUNT-1:0] flush_done,
    input  logic [`CACHE_COUNT-1:0] clear_done
);
    localparam int ICACHE = 0;
    localparam int DCACHE = 1;

    logic [`CACHE_COUNT-1:0] flush_op;
    logic [`CACHE_COUNT-1:0] clear_op;
    logic [`CACHE_COUNT-1:0] flush_left;
    logic [`CACHE_COUNT-1:0] clear_left;

    // opcode to per-cache requests
    always_comb begin
        flush_op = '0;
        clear_op = '0;
        case (fence_op)
            FENCE_I: clear_op[ICACHE] = 1'b1;
            FENCE_D: flush_op[DCACHE] = 1'b1;
            FENCE_ALL: begin
                flush_op[DCACHE] = 1'b1;
                clear_op[ICACHE] = 1'b1;
            end
            default: ;
        endcase
    end

    // bits still waiting on their done
    assign flush_left = flush & ~flush_done;
    assign clear_left = clear & ~clear_done;

    always_ff @(posedge CLK) begin
        if (rst) begin
            fence_busy <= 1'b0;
            flush      <= '0;
            clear      <= '0;
        end else if (!fence_busy) begin
            if (fence_req) begin
                flush      <= flush_op;
                clear      <= clear_op;
                fence_busy <= 1'b1;
            end
        end else begin
            flush <= flush_left;
            clear <= clear_left;
            // last done seen this cycle
            if (flush_left == '0 && clear_left == '0) fence_busy <= 1'b0;
        end
    end

endmodule

//--- mem_arbiter.sv
// fixed-priority arbiter merging the cache memory buses onto one memory bus
`timescale 1ns/100ps
`include "cache_defines.svh"

module mem_arbiter
    import cache_pkg::*;
(
    input  logic                     CLK,
    input  logic                     rst,
    input  logic [`CACHE_ADDR_W-1:0] req_addr  [`CACHE_COUNT],
    input  logic [`CACHE_COUNT-1:0]  req_ren,
    input  logic [`CACHE_COUNT-1:0]  req_wen,
    input  logic [`CACHE_DATA_W-1:0] req_wdata [`CACHE_COUNT],
    output logic [`CACHE_DATA_W-1:0] req_rdata [`CACHE_COUNT],
    output logic [`CACHE_COUNT-1:0]  req_busy,
    output logic [`CACHE_ADDR_W-1:0] mem_addr,
    output logic                     mem_ren,
    output logic                     mem_wen,
    output logic [`CACHE_DATA_W-1:0] mem_wdata,
    input  logic [`CACHE_DATA_W-1:0] mem_rdata,
    input  logic                     mem_busy
);
    localparam int GNT_W = (`CACHE_COUNT > 1) ? $clog2(`CACHE_COUNT) : 1;

    arb_state_t       state;
    logic [GNT_W-1:0] grant;
    logic [GNT_W-1:0] pick;
    logic             any_req;
    logic             gnt_active;

    // highest index wins, so the data cache goes first
    always_comb begin
        pick    = '0;
        any_req = 1'b0;
        for (int i = 0; i < `CACHE_COUNT; i++) begin
            if (req_ren[i] | req_wen[i]) begin
                pick    = GNT_W'(i);
                any_req = 1'b1;
            end
        end
    end

    assign gnt_active = req_ren[grant] | req_wen[grant];

    always_ff @(posedge CLK) begin
        if (rst) begin
            state <= ARB_IDLE;
            grant <= '0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (any_req) begin
                        grant <= pick;
                        state <= ARB_BUSY;
                    end
                end
                // release once the memory finishes the transfer
                ARB_BUSY: if (!gnt_active || !mem_busy) state <= ARB_IDLE;
                default:  state <= ARB_IDLE;
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // bus muxing
    // ----------------------------------------------------------------------
    assign mem_addr  = req_addr[grant];
    assign mem_wdata = req_wdata[grant];
    assign mem_ren   = (state == ARB_BUSY) & req_ren[grant];
    assign mem_wen   = (state == ARB_BUSY) & req_wen[grant];

    always_comb begin
        for (int i = 0; i < `CACHE_COUNT; i++) begin
            if (state == ARB_BUSY && grant == GNT_W'(i)) begin
                req_rdata[i] = mem_rdata;
                req_busy[i]  = mem_busy;
            end else begin
                req_rdata[i] = '0;
                req_busy[i]  = 1'b1;
            end
        end
    end

endmodule

//--- project.f
+incdir+.
cache_pkg.sv
direct_mapped_cache.sv
fence_sequencer.sv
mem_arbiter.sv
separate_caches.sv
separate_caches_sva.sv
tb_separate_caches.sv

//--- separate_caches.sv
// split instruction and data caches with fence sequencer and shared memory arbiter
`timescale 1ns/100ps
`include "cache_defines.svh"

module separate_caches
    import cache_pkg::*;
(
    input  logic                     CLK,
    input  logic                     rst,
    input  logic [`CACHE_ADDR_W-1:0] iproc_addr,
    input  logic                     iproc_ren,
    input  logic                     iproc_wen,
    input  logic [`CACHE_DATA_W-1:0] iproc_wdata,
    output logic [`CACHE_DATA_W-1:0] iproc_rdata,
    output logic                     iproc_busy,
    input  logic [`CACHE_ADDR_W-1:0] dproc_addr,
    input  logic                     dproc_ren,
    input  logic                     dproc_wen,
    input  logic [`CACHE_DATA_W-1:0] dproc_wdata,
    output logic [`CACHE_DATA_W-1:0] dproc_rdata,
    output logic                     dproc_busy,
    input  logic                     fence_req,
    input  fence_op_t                fence_op,
    output logic                     fence_busy,
    output logic [`CACHE_ADDR_W-1:0] mem_addr,
    output logic                     mem_ren,
    output logic                     mem_wen,
    output logic [`CACHE_DATA_W-1:0] mem_wdata,
    input  logic [`CACHE_DATA_W-1:0] mem_rdata,
    input  logic                     mem_busy
);
    // processor buses, index 0 instruction, index 1 data
    logic [`CACHE_ADDR_W-1:0] p_addr  [`CACHE_COUNT];
    logic [`CACHE_COUNT-1:0]  p_ren;
    logic [`CACHE_COUNT-1:0]  p_wen;
    logic [`CACHE_DATA_W-1:0] p_wdata [`CACHE_COUNT];
    logic [`CACHE_DATA_W-1:0] p_rdata [`CACHE_COUNT];
    logic [`CACHE_COUNT-1:0]  p_busy;

    // cache to arbiter
    logic [`CACHE_ADDR_W-1:0] c_addr  [`CACHE_COUNT];
    logic [`CACHE_COUNT-1:0]  c_ren;
    logic [`CACHE_COUNT-1:0]  c_wen;
    logic [`CACHE_DATA_W-1:0] c_wdata [`CACHE_COUNT];
    logic [`CACHE_DATA_W-1:0] c_rdata [`CACHE_COUNT];
    logic [`CACHE_COUNT-1:0]  c_busy;

    logic [`CACHE_COUNT-1:0]  flush;
    logic [`CACHE_COUNT-1:0]  clear;
    logic [`CACHE_COUNT-1:0]  flush_done;
    logic [`CACHE_COUNT-1:0]  clear_done;

    assign p_addr[0]   = iproc_addr;
    assign p_ren[0]    = iproc_ren;
    assign p_wen[0]    = iproc_wen;
    assign p_wdata[0]  = iproc_wdata;
    assign iproc_rdata = p_rdata[0];
    assign iproc_busy  = p_busy[0];
    assign p_addr[1]   = dproc_addr;
    assign p_ren[1]    = dproc_ren;
    assign p_wen[1]    = dproc_wen;
    assign p_wdata[1]  = dproc_wdata;
    assign dproc_rdata = p_rdata[1];
    assign dproc_busy  = p_busy[1];

    fence_sequencer i_fence_sequencer (
        .CLK        (CLK),
        .rst        (rst),
        .fence_req  (fence_req),
        .fence_op   (fence_op),
        .fence_busy (fence_busy),
        .flush      (flush),
        .clear      (clear),
        .flush_done (flush_done),
        .clear_done (clear_done)
    );

    for (genvar g = 0; g < `CACHE_COUNT; g++) begin : g_cache
        direct_mapped_cache i_cache (
            .CLK        (CLK),
            .rst        (rst),
            .proc_addr  (p_addr[g]),
            .proc_ren   (p_ren[g]),
            .proc_wen   (p_wen[g]),
            .proc_wdata (p_wdata[g]),
            .proc_rdata (p_rdata[g]),
            .proc_busy  (p_busy[g]),
            .mem_addr   (c_addr[g]),
            .mem_ren    (c_ren[g]),
            .mem_wen    (c_wen[g]),
            .mem_wdata  (c_wdata[g]),
            .mem_rdata  (c_rdata[g]),
            .mem_busy   (c_busy[g]),
            .flush      (flush[g]),
            .clear      (clear[g]),
            .flush_done (flush_done[g]),
            .clear_done (clear_done[g])
        );
    end

    mem_arbiter i_mem_arbiter (
        .CLK       (CLK),
        .rst       (rst),
        .req_addr  (c_addr),
        .req_ren   (c_ren),
        .req_wen   (c_wen),
        .req_wdata (c_wdata),
        .req_rdata (c_rdata),
        .req_busy  (c_busy),
        .mem_addr  (mem_addr),
        .mem_ren   (mem_ren),
        .mem_wen   (mem_wen),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_busy  (mem_busy)
    );

endmodule

//--- separate_caches_sva.sv
// concurrent checks on the memory bus, fence busy and processor request stability
`timescale 1ns/100ps

module separate_caches_sva (
    input logic        CLK,
    input logic        rst,
    input logic        mem_ren,
    input logic        mem_wen,
    input logic        fence_busy,
    input logic [31:0] iproc_addr,
    input logic        iproc_ren,
    input logic        iproc_wen,
    input logic        iproc_busy,
    input logic [31:0] dproc_addr,
    input logic        dproc_ren,
    input logic        dproc_wen,
    input logic        dproc_busy
);
    int fail_count = 0;

    // one direction per memory transfer
    a_mem_dir: assert property (@(posedge CLK) disable iff (rst) !(mem_ren && mem_wen))
        else begin fail_count++; $error("memory read and write high together"); end

    a_fence_hold: assert property (@(posedge CLK) disable iff (rst)
        $fell(fence_busy) |-> $past(fence_busy, 2))
        else begin fail_count++; $error("fence busy dropped after a single cycle"); end

    // requester keeps its address until the access completes
    a_iaddr: assert property (@(posedge CLK) disable iff (rst)
        (iproc_ren || iproc_wen) && iproc_busy |=> $stable(iproc_addr))
        else begin fail_count++; $error("instruction address moved while busy"); end

    a_daddr: assert property (@(posedge CLK) disable iff (rst)
        (dproc_ren || dproc_wen) && dproc_busy |=> $stable(dproc_addr))
        else begin fail_count++; $error("data address moved while busy"); end

endmodule

//--- tb_separate_caches.sv
// testbench with clock, reset, memory model, stimulus table and checks for the split caches
`timescale 1ns/100ps
`include "cache_defines.svh"

module tb_separate_caches
    import cache_pkg::*;
;
    localparam logic PORT_I = 1'b0;
    localparam logic PORT_D = 1'b1;

    typedef enum logic [1:0] {OP_RD, OP_WR, OP_FENCE, OP_POKE} step_op_t;

    typedef struct packed {
        logic        port;
        step_op_t    op;
        logic        hit;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] exp;
        int          exp_rd;
        int          exp_wr;
    } step_t;

    logic        CLK;
    logic        rst;
    logic [31:0] iproc_addr, iproc_wdata, iproc_rdata;
    logic        iproc_ren, iproc_wen, iproc_busy;
    logic [31:0] dproc_addr, dproc_wdata, dproc_rdata;
    logic        dproc_ren, dproc_wen, dproc_busy;
    logic        fence_req, fence_busy;
    fence_op_t   fence_op;
    logic [31:0] mem_addr, mem_wdata, mem_rdata;
    logic        mem_ren, mem_wen, mem_busy;

    // memory model and its transfer counts
    logic [31:0] mem_words [logic [31:0]];
    int          rd_cnt [logic [31:0]];
    int          wr_total = 0;
    int          wait_cnt;

    // shadow state used to build expected values
    logic [31:0]            s_mem [logic [31:0]];
    logic [`CACHE_SETS-1:0] s_valid [2];
    logic [`CACHE_SETS-1:0] s_dirty [2];
    logic [31:0]            s_line [2][`CACHE_SETS];
    logic [31:0]            s_data [2][`CACHE_SETS];

    step_t steps [$];
    int    errors = 0;
    int    checks = 0;
    int    cycles = 0;
    int    cycle_limit = 0;

    separate_caches i_separate_caches (.*);

    bind separate_caches separate_caches_sva i_sva (
        .CLK(CLK), .rst(rst), .mem_ren(mem_ren), .mem_wen(mem_wen), .fence_busy(fence_busy),
        .iproc_addr(iproc_addr), .iproc_ren(iproc_ren), .iproc_wen(iproc_wen),
        .iproc_busy(iproc_busy), .dproc_addr(dproc_addr), .dproc_ren(dproc_ren),
        .dproc_wen(dproc_wen), .dproc_busy(dproc_busy)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    // ----------------------------------------------------------------------
    // memory model
    // ----------------------------------------------------------------------
    // unwritten words follow an address pattern
    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return {a[15:0], a[31:16]} ^ 32'h6b3d_91c5;
    endfunction

    function automatic logic [31:0] mem_read(input logic [31:0] a);
        return mem_words.exists(a) ? mem_words[a] : fill_word(a);
    endfunction

    function automatic logic [31:0] shadow_read(input logic [31:0] a);
        return s_mem.exists(a) ? s_mem[a] : fill_word(a);
    endfunction

    function automatic int read_count(input logic [31:0] a);
        return rd_cnt.exists(a) ? rd_cnt[a] : 0;
    endfunction

    // transfer completes at the next edge when busy is low at the negedge
    always begin
        @(negedge CLK);
        if ((mem_ren || mem_wen) && !mem_busy) begin
            if (mem_wen) begin
                mem_words[mem_addr] = mem_wdata;
                wr_total++;
            end else begin
                rd_cnt[mem_addr] = read_count(mem_addr) + 1;
            end
            wait_cnt = $urandom_range(3, 0);
        end else if ((mem_ren || mem_wen) && wait_cnt != 0) begin
            wait_cnt--;
        end
        @(posedge CLK);
        #10;
        mem_busy  = (mem_ren || mem_wen) && wait_cnt != 0;
        mem_rdata = mem_read(mem_addr);
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycle_limit != 0 && cycles > cycle_limit) begin
            $display("timeout after %0d cycles with %0d errors", cycles, errors);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERR %0t %s exp %h got %h", $time, name, exp, got);
        end
    endtask

    // ----------------------------------------------------------------------
    // stimulus table with expected values
    // ----------------------------------------------------------------------
    task automatic add_step(input logic port, input step_op_t op, input logic [31:0] a,
                            input logic [31:0] d);
        step_t     s;
        int        i;
        int        n;
        fence_op_t fop;
        s = '{port: port, op: op, hit: 1'b0, addr: a, data: d, exp: '0, exp_rd: 0,
              exp_wr: 0};
        i = a[5:2];
        fop = fence_op_t'(d[1:0]);
        if (op == OP_POKE) begin
            s_mem[a] = d;
        end else if (op == OP_FENCE) begin
            for (n = 0; n < `CACHE_SETS; n++) begin
                if (fop != FENCE_I && s_valid[1][n] && s_dirty[1][n]) begin
                    s_mem[s_line[1][n]] = s_data[1][n];
                    s.exp_wr++;
                end
                if (fop != FENCE_I) s_valid[1][n] = 1'b0;
                if (fop != FENCE_D) s_valid[0][n] = 1'b0;
            end
        end else if (a >= `CACHE_NONCACHE_START) begin
            if (op == OP_WR) begin
                s_mem[a] = d;
                s.exp_wr = 1;
            end else begin
                s.exp    = shadow_read(a);
                s.exp_rd = 1;
            end
        end else begin
            s.hit = s_valid[port][i] && s_line[port][i] == a;
            if (!s.hit) begin
                // victim goes out before the fill
                if (s_valid[port][i] && s_dirty[port][i]) begin
                    s_mem[s_line[port][i]] = s_data[port][i];
                    s.exp_wr = 1;
                end
                s_valid[port][i] = 1'b1;
                s_dirty[port][i] = 1'b0;
                s_line[port][i]  = a;
                s_data[port][i]  = shadow_read(a);
                s.exp_rd = 1;
            end
            if (op == OP_WR) begin
                s_data[port][i]  = d;
                s_dirty[port][i] = 1'b1;
            end
            s.exp = s_data[port][i];
        end
        steps.push_back(s);
    endtask

    task automatic build_steps();
        logic [31:0] a;
        logic        port;
        s_valid = '{default: '0};
        s_dirty = '{default: '0};
        // first reads fill, repeats hit
        add_step(PORT_I, OP_RD, 32'h0000_1000, '0);
        add_step(PORT_I, OP_RD, 32'h0000_1000, '0);
        add_step(PORT_D, OP_RD, 32'h0000_2004, '0);
        add_step(PORT_D, OP_RD, 32'h0000_2004, '0);
        // write allocate and write hit stay in the cache
        add_step(PORT_D, OP_WR, 32'h0000_2008, 32'h1111_2222);
        add_step(PORT_D, OP_RD, 32'h0000_2008, '0);
        add_step(PORT_D, OP_WR, 32'h0000_2004, 32'hcafe_0001);
        add_step(PORT_D, OP_WR, 32'h0000_200c, 32'hbeef_0003);
        add_step(PORT_D, OP_FENCE, '0, 32'(FENCE_D));
        add_step(PORT_I, OP_RD, 32'h0000_2008, '0);
        // stale line until the instruction cache is cleared
        add_step(PORT_D, OP_POKE, 32'h0000_1000, 32'h7777_0000);
        add_step(PORT_I, OP_RD, 32'h0000_1000, '0);
        add_step(PORT_D, OP_FENCE, '0, 32'(FENCE_I));
        add_step(PORT_I, OP_RD, 32'h0000_1000, '0);
        // uncached region
        add_step(PORT_D, OP_RD, 32'hf000_0010, '0);
        add_step(PORT_D, OP_RD, 32'hf000_0010, '0);
        add_step(PORT_D, OP_WR, 32'hf000_0010, 32'h5555_aaaa);
        add_step(PORT_D, OP_RD, 32'hf000_0010, '0);
        add_step(PORT_I, OP_RD, 32'hf000_0020, '0);
        // conflicting sets with dirty evictions
        add_step(PORT_D, OP_WR, 32'h0000_3010, 32'ha000_0001);
        add_step(PORT_I, OP_RD, 32'h0000_4010, '0);
        add_step(PORT_D, OP_WR, 32'h0000_5010, 32'ha000_0002);
        add_step(PORT_I, OP_RD, 32'h0000_6010, '0);
        add_step(PORT_D, OP_RD, 32'h0000_3010, '0);
        add_step(PORT_I, OP_RD, 32'h0000_3010, '0);
        add_step(PORT_D, OP_RD, 32'h0000_5010, '0);
        repeat (24) begin
            a = 32'h0000_3000 + ($urandom_range(3, 0) << 8) + ($urandom_range(3, 0) << 2);
            port = 1'($urandom_range(1, 0));
            if (port == PORT_I || $urandom_range(2, 0) == 0) add_step(port, OP_RD, a, '0);
            else add_step(port, OP_WR, a, $urandom);
        end
        add_step(PORT_D, OP_FENCE, '0, 32'(FENCE_ALL));
    endtask

    // ----------------------------------------------------------------------
    // drivers
    // ----------------------------------------------------------------------
    task automatic access(input logic port, input logic wr, input logic [31:0] a,
                          input logic [31:0] wd, output logic [31:0] rd,
                          output int stalls);
        logic busy;
        if (port == PORT_D) begin
            dproc_addr  = a;
            dproc_wdata = wd;
            dproc_ren   = !wr;
            dproc_wen   = wr;
        end else begin
            iproc_addr  = a;
            iproc_wdata = wd;
            iproc_ren   = !wr;
            iproc_wen   = wr;
        end
        stalls = 0;
        busy   = 1'b1;
        while (busy) begin
            @(negedge CLK);
            busy = (port == PORT_D) ? dproc_busy : iproc_busy;
            rd   = (port == PORT_D) ? dproc_rdata : iproc_rdata;
            if (busy) stalls++;
        end
        @(posedge CLK);
        #10;
        {iproc_ren, iproc_wen, dproc_ren, dproc_wen} = '0;
    endtask

    task automatic run_fence(input fence_op_t op);
        fence_req = 1'b1;
        fence_op  = op;
        @(posedge CLK);
        #10;
        fence_req = 1'b0;
        @(negedge CLK);
        check_value("fence_busy", 32'd1, 32'(fence_busy));
        while (fence_busy) @(negedge CLK);
        @(posedge CLK);
        #10;
    endtask

    task automatic run_step(input step_t s);
        logic [31:0] got;
        int          stalls;
        int          rd0;
        int          wr0;
        rd0 = read_count(s.addr);
        wr0 = wr_total;
        case (s.op)
            OP_RD, OP_WR: begin
                access(s.port, s.op == OP_WR, s.addr, s.data, got, stalls);
                // a hit completes with busy low, anything else stalls
                check_value(s.port ? "dproc_busy" : "iproc_busy", 32'(!s.hit),
                            32'(stalls != 0));
                if (s.op == OP_RD) begin
                    check_value(s.port ? "dproc_rdata" : "iproc_rdata", s.exp, got);
                end
            end
            OP_FENCE: run_fence(fence_op_t'(s.data[1:0]));
            default:  mem_words[s.addr] = s.data;
        endcase
        check_value("mem_ren count", s.exp_rd, read_count(s.addr) - rd0);
        check_value("mem_wen count", s.exp_wr, wr_total - wr0);
    endtask

    initial begin
        void'($urandom(32'h26da));
        rst = 1'b1;
        {iproc_addr, iproc_wdata, dproc_addr, dproc_wdata} = '0;
        {iproc_ren, iproc_wen, dproc_ren, dproc_wen} = '0;
        fence_req = 1'b0;
        fence_op  = FENCE_I;
        mem_busy  = 1'b0;
        mem_rdata = '0;
        wait_cnt  = 0;
        build_steps();
        cycle_limit = steps.size() * 40;
        repeat (8) @(posedge CLK);
        #10;
        rst = 1'b0;
        foreach (steps[k]) run_step(steps[k]);
        // everything dirty has been flushed by the last fence
        foreach (s_mem[a]) check_value($sformatf("mem[%h]", a), s_mem[a], mem_read(a));
        errors += i_separate_caches.i_sva.fail_count;
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
